//--- design/ex_ft_pkg.sv
`default_nettype none

package ex_ft_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // datapath width of every lane
  localparam int unsigned XLEN       = 32;
  // destination register index width
  localparam int unsigned REG_ADDR_W = 5;
  // redundant alu copies
  localparam int unsigned N_LANES    = 3;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  // three bit encoding, all eight codes in use
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6,
    OP_SLT = 3'd7
  } alu_op_e;

  // one bit per lane, bit i belongs to lane i
  typedef logic [N_LANES-1:0] lane_mask_t;

  //////////////////////////////////////////////////
  // pipeline payloads
  //////////////////////////////////////////////////

  // request from decode into the execute stage
  typedef struct packed {
    alu_op_e               op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] waddr;
  } ex_req_t;

  // the three lane results after the first register
  typedef struct packed {
    logic [N_LANES-1:0][XLEN-1:0] res;
    logic [REG_ADDR_W-1:0]        waddr;
  } lane_res_t;

  // voted result plus error summary, this is what writeback sees
  typedef struct packed {
    logic [XLEN-1:0]       wdata;
    logic [REG_ADDR_W-1:0] waddr;
    logic                  err_detected;
    logic                  err_corrected;
    logic                  err_uncorrectable;
  } vote_t;

endpackage

`default_nettype wire

//--- design/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane import ex_ft_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o
);

  // shift amount comes from the low bits of operand b
  localparam int unsigned SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;

  assign shamt     = operand_b_i[SHAMT_W-1:0];
  assign lt_signed = $signed(operand_a_i) < $signed(operand_b_i);

  //////////////////////////////////////////////////
  // operation select
  //////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      OP_ADD: begin
        result_o = operand_a_i + operand_b_i;
      end
      OP_SUB: begin
        result_o = operand_a_i - operand_b_i;
      end
      OP_AND: begin
        result_o = operand_a_i & operand_b_i;
      end
      OP_OR: begin
        result_o = operand_a_i | operand_b_i;
      end
      OP_XOR: begin
        result_o = operand_a_i ^ operand_b_i;
      end
      // logical shifts only, no arithmetic right shift here
      OP_SLL: begin
        result_o = operand_a_i << shamt;
      end
      OP_SRL: begin
        result_o = operand_a_i >> shamt;
      end
      // set-less-than gives 0 or 1
      OP_SLT: begin
        result_o = XLEN'(lt_signed);
      end
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/alu_tmr_stage.sv
`timescale 1ns/1ps
`default_nettype none

module alu_tmr_stage import ex_ft_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // request side
  input  logic       in_valid_i,
  output logic       in_ready_o,
  input  ex_req_t    req_i,
  input  lane_mask_t fault_inject_i,
  // towards the voter and writeback
  output logic       out_valid_o,
  output lane_res_t  out_o,
  input  logic       out_ready_i
);

  logic [N_LANES-1:0][XLEN-1:0] lane_out;
  logic [N_LANES-1:0][XLEN-1:0] lane_res;
  logic                         valid_q;
  lane_res_t                    res_q;
  logic                         accept;

  //////////////////////////////////////////////////
  // redundant lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    alu_lane u_alu_lane (
      .op_i        (req_i.op),
      .operand_a_i (req_i.operand_a),
      .operand_b_i (req_i.operand_b),
      .result_o    (lane_out[i])
    );

    // injected fault flips bit 0 of this lane only
    assign lane_res[i] = lane_out[i] ^ XLEN'(fault_inject_i[i]);
  end

  //////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////

  // free slot, or the item leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // drains to empty when nothing new is offered
      valid_q <= in_valid_i;
    end
  end

  // payload only moves on a real transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      res_q.res   <= lane_res;
      res_q.waddr <= req_i.waddr;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = res_q;

  // upstream must keep offering a request it could not hand over
  a_req_held : assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid_i && !in_ready_o) |=> in_valid_i
  ) else $warning("request withdrawn while the execute stage was stalled");

endmodule

`default_nettype wire

//--- design/majority_voter.sv
`timescale 1ns/1ps
`default_nettype none

module majority_voter import ex_ft_pkg::*; (
  input  lane_res_t  res_i,
  input  lane_mask_t faulty_i,
  output vote_t      vote_o,
  output lane_mask_t mismatch_o
);

  logic [XLEN-1:0] maj;
  logic [XLEN-1:0] lo_res;
  logic [XLEN-1:0] hi_res;
  logic            pair_mode;
  lane_mask_t      diff;

  //////////////////////////////////////////////////
  // bitwise 2-of-3 majority
  //////////////////////////////////////////////////

  assign maj = (res_i.res[0] & res_i.res[1])
             | (res_i.res[0] & res_i.res[2])
             | (res_i.res[1] & res_i.res[2]);

  // lanes that disagree with the majority
  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      diff[i] = (res_i.res[i] != maj);
    end
  end

  //////////////////////////////////////////////////
  // mode select on the faulty mask
  //////////////////////////////////////////////////

  always_comb begin
    vote_o.waddr             = res_i.waddr;
    vote_o.wdata             = res_i.res[0];
    vote_o.err_detected      = 1'b0;
    vote_o.err_corrected     = 1'b0;
    vote_o.err_uncorrectable = 1'b0;
    mismatch_o               = '0;
    pair_mode                = 1'b0;
    lo_res                   = res_i.res[0];
    hi_res                   = res_i.res[1];

    case (faulty_i)
      // full tmr, a single bad lane is masked
      3'b000: begin
        vote_o.wdata         = maj;
        mismatch_o           = diff;
        vote_o.err_detected  = |diff;
        vote_o.err_corrected = |diff;
      end
      // one lane gone, duplex compare of the other two
      3'b001: begin
        pair_mode = 1'b1;
        lo_res    = res_i.res[1];
        hi_res    = res_i.res[2];
      end
      3'b010: begin
        pair_mode = 1'b1;
        lo_res    = res_i.res[0];
        hi_res    = res_i.res[2];
      end
      3'b100: begin
        pair_mode = 1'b1;
        lo_res    = res_i.res[0];
        hi_res    = res_i.res[1];
      end
      // simplex, trust the last healthy lane
      3'b011: begin
        vote_o.wdata = res_i.res[2];
      end
      3'b101: begin
        vote_o.wdata = res_i.res[1];
      end
      // lane 0 survives, or nothing does and lane 0 is passed anyway
      default: begin
        vote_o.wdata = res_i.res[0];
      end
    endcase

    // in duplex we cannot tell which lane is wrong, so nobody is blamed
    if (pair_mode) begin
      vote_o.wdata = lo_res;
      if (lo_res != hi_res) begin
        vote_o.err_detected      = 1'b1;
        vote_o.err_uncorrectable = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fault_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fault_monitor import ex_ft_pkg::*; #(
  parameter int unsigned PERM_FAULT_LIMIT = 3
) (
  input  logic       clk,
  input  logic       rst_n,
  // high on the cycle a voted item is handed to writeback
  input  logic       count_en_i,
  input  lane_mask_t mismatch_i,
  output lane_mask_t faulty_o
);

  // counter just wide enough to hold the limit
  localparam int unsigned CNT_W = $clog2(PERM_FAULT_LIMIT + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(PERM_FAULT_LIMIT);

  logic [N_LANES-1:0][CNT_W-1:0] cnt_q;
  logic [N_LANES-1:0][CNT_W-1:0] cnt_d;
  lane_mask_t                    faulty_q;
  lane_mask_t                    hit_limit;

  //////////////////////////////////////////////////
  // saturating disagreement counters
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      cnt_d[i] = cnt_q[i];
      // stop at the limit, no wrap
      if (count_en_i && mismatch_i[i] && (cnt_q[i] != CNT_MAX)) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      hit_limit[i] = (cnt_d[i] == CNT_MAX);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      faulty_q <= '0;
    end else begin
      cnt_q    <= cnt_d;
      // sticky, only reset clears a permanent fault
      faulty_q <= faulty_q | hit_limit;
    end
  end

  // feeds the voter in the same cycle, so only later items see the change
  assign faulty_o = faulty_q;

  a_faulty_sticky : assert property (
    @(posedge clk) disable iff (!rst_n)
    (($past(faulty_q) & ~faulty_q) == '0)
  ) else $error("permanent fault flag cleared without reset");

endmodule

`default_nettype wire

//--- design/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage import ex_ft_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // from the voter
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  vote_t vote_i,
  // writeback port
  output logic  wb_valid_o,
  output vote_t wb_o,
  input  logic  wb_ready_i
);

  logic  valid_q;
  vote_t wb_q;

  //////////////////////////////////////////////////
  // ex/wb register
  //////////////////////////////////////////////////

  // empty, or the consumer takes the current item this cycle
  assign in_ready_o = !valid_q || wb_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // consumed with nothing behind it leaves the register empty
      valid_q <= in_valid_i;
    end
  end

  // result and flags stay put while stalled
  always_ff @(posedge clk) begin
    if (in_valid_i && in_ready_o) begin
      wb_q <= vote_i;
    end
  end

  assign wb_valid_o = valid_q;
  assign wb_o       = wb_q;

  // a stalled output must not change under the consumer
  a_wb_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_valid_o && !wb_ready_i) |=> (wb_valid_o && $stable(wb_o))
  ) else $error("writeback output changed while stalled");

endmodule

`default_nettype wire

//--- design/ex_stage_ft.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_ft import ex_ft_pkg::*; #(
  parameter int unsigned PERM_FAULT_LIMIT = 3
) (
  input  logic       clk,
  input  logic       rst_n,
  // request port
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  ex_req_t    req_i,
  input  lane_mask_t fault_inject_i,
  // writeback port
  output logic       wb_valid_o,
  output vote_t      wb_o,
  input  logic       wb_ready_i,
  // permanent fault status per lane
  output lane_mask_t lane_faulty_o
);

  logic       tmr_valid;
  lane_res_t  tmr_res;
  logic       wb_in_ready;
  vote_t      vote;
  lane_mask_t mismatch;
  lane_mask_t faulty;
  logic       count_en;

  //////////////////////////////////////////////////
  // stage 1, three lanes and their register
  //////////////////////////////////////////////////

  alu_tmr_stage u_alu_tmr_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (req_valid_i),
    .in_ready_o     (req_ready_o),
    .req_i          (req_i),
    .fault_inject_i (fault_inject_i),
    .out_valid_o    (tmr_valid),
    .out_o          (tmr_res),
    .out_ready_i    (wb_in_ready)
  );

  // voter and monitor sit between the two registers
  majority_voter u_majority_voter (
    .res_i      (tmr_res),
    .faulty_i   (faulty),
    .vote_o     (vote),
    .mismatch_o (mismatch)
  );

  // count each item once, on its move into writeback
  assign count_en = tmr_valid && wb_in_ready;

  fault_monitor #(
    .PERM_FAULT_LIMIT (PERM_FAULT_LIMIT)
  ) u_fault_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .count_en_i (count_en),
    .mismatch_i (mismatch),
    .faulty_o   (faulty)
  );

  //////////////////////////////////////////////////
  // stage 2, writeback register
  //////////////////////////////////////////////////

  wb_stage u_wb_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (tmr_valid),
    .in_ready_o (wb_in_ready),
    .vote_i     (vote),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .wb_ready_i (wb_ready_i)
  );

  assign lane_faulty_o = faulty;

endmodule

`default_nettype wire

//--- dv/clk_rst_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // reset held for a fixed number of rising edges, released on an edge
  initial begin
    rst_n_o <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/tb_ex_stage_ft.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage_ft import ex_ft_pkg::*; ();

  localparam int unsigned PERM_FAULT_LIMIT = 3;
  localparam int unsigned TBL_LEN = 17;
  localparam int unsigned N_RAND  = 40;
  localparam int unsigned TOTAL   = TBL_LEN + N_RAND;
  // four cycles per entry is generous even with half the cycles stalled
  localparam int unsigned TIMEOUT = 4 * TOTAL + 50;

  // one table row, flags are {detected, corrected, uncorrectable}
  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    lane_mask_t      inj;
    logic [XLEN-1:0] wdata;
    logic [2:0]      flags;
    lane_mask_t      faulty;
  } stim_t;

  // scoreboard entry for one accepted request
  typedef struct packed {
    vote_t       vote;
    lane_mask_t  faulty;
    int unsigned acc_cycle;
    logic        lat_chk;
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  ex_req_t     req;
  lane_mask_t  fault_inject;
  logic        wb_valid;
  vote_t       wb;
  logic        wb_ready;
  lane_mask_t  lane_faulty;

  stim_t       stim_tbl[$];
  exp_t        exp_q[$];
  exp_t        cur_exp;
  logic [31:0] lfsr_state;
  int unsigned src_idx = 0;
  int unsigned pops    = 0;
  int unsigned cycle   = 0;
  logic        stalled = 1'b0;
  vote_t       held;

  clk_rst_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (5)
  ) u_clk_rst_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ex_stage_ft #(
    .PERM_FAULT_LIMIT (PERM_FAULT_LIMIT)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_ready_o    (req_ready),
    .req_i          (req),
    .fault_inject_i (fault_inject),
    .wb_valid_o     (wb_valid),
    .wb_o           (wb),
    .wb_ready_i     (wb_ready),
    .lane_faulty_o  (lane_faulty)
  );

  //////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic fail_value(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_vote(input vote_t got, input vote_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf(
        "%s: got wdata %h waddr %0d flags %b, expected wdata %h waddr %0d flags %b",
        what, got.wdata, got.waddr,
        {got.err_detected, got.err_corrected, got.err_uncorrectable},
        exp.wdata, exp.waddr,
        {exp.err_detected, exp.err_corrected, exp.err_uncorrectable}));
    end
  endtask

  task automatic check_faulty(input lane_mask_t got, input lane_mask_t exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: lane_faulty_o %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_value($sformatf("%s: req_ready_o %b, expected %b", what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit, bits shift in from the right
  task automatic take_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [XLEN-1:0] alu_rule(input alu_op_e op, input logic [XLEN-1:0] a,
                                               input logic [XLEN-1:0] b);
    logic [XLEN-1:0] r;
    case (op)
      OP_ADD: r = a + b;
      OP_SUB: r = a - b;
      OP_AND: r = a & b;
      OP_OR:  r = a | b;
      OP_XOR: r = a ^ b;
      // shift amount is b[4:0]
      OP_SLL: r = a << b[4:0];
      OP_SRL: r = a >> b[4:0];
      OP_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default: r = '0;
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic add_entry(input alu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                           input lane_mask_t inj, input logic [XLEN-1:0] wdata,
                           input logic [2:0] flags, input lane_mask_t faulty);
    stim_t s;
    s.op     = op;
    s.a      = a;
    s.b      = b;
    s.inj    = inj;
    s.wdata  = wdata;
    s.flags  = flags;
    s.faulty = faulty;
    stim_tbl.push_back(s);
  endtask

  task automatic fill_table();
    // every opcode, clean lanes
    add_entry(OP_ADD, 32'h0000_1234, 32'h0000_0f0f, 3'b000, 32'h0000_2143, 3'b000, 3'b000);
    add_entry(OP_SUB, 32'h0000_0010, 32'h0000_0020, 3'b000, 32'hffff_fff0, 3'b000, 3'b000);
    add_entry(OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 3'b000, 32'hf000_f000, 3'b000, 3'b000);
    add_entry(OP_OR,  32'h0f0f_0000, 32'h0000_00f0, 3'b000, 32'h0f0f_00f0, 3'b000, 3'b000);
    add_entry(OP_XOR, 32'haaaa_5555, 32'hffff_0000, 3'b000, 32'h5555_5555, 3'b000, 3'b000);
    // only the low five bits of b count, 0x24 shifts by 4
    add_entry(OP_SLL, 32'h0000_0003, 32'h0000_0024, 3'b000, 32'h0000_0030, 3'b000, 3'b000);
    add_entry(OP_SRL, 32'h8000_0000, 32'h0000_001f, 3'b000, 32'h0000_0001, 3'b000, 3'b000);
    add_entry(OP_SLT, 32'hffff_ffff, 32'h0000_0001, 3'b000, 32'h0000_0001, 3'b000, 3'b000);
    // single lane upsets, masked by the vote
    add_entry(OP_ADD, 32'h0000_0001, 32'h0000_0002, 3'b001, 32'h0000_0003, 3'b110, 3'b000);
    add_entry(OP_XOR, 32'h1234_5678, 32'h0000_ffff, 3'b100, 32'h1234_a987, 3'b110, 3'b000);
    // lane 1 keeps disagreeing until it is retired
    add_entry(OP_ADD, 32'h0000_0010, 32'h0000_0020, 3'b010, 32'h0000_0030, 3'b110, 3'b000);
    add_entry(OP_SUB, 32'h0000_0100, 32'h0000_0001, 3'b010, 32'h0000_00ff, 3'b110, 3'b000);
    add_entry(OP_OR,  32'h0000_00f0, 32'h0000_000f, 3'b010, 32'h0000_00ff, 3'b110, 3'b010);
    add_entry(OP_AND, 32'hffff_ffff, 32'h1357_9bdf, 3'b010, 32'h1357_9bdf, 3'b000, 3'b010);
    // duplex on lanes 0 and 2, disagreement cannot be corrected
    add_entry(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 3'b100, 32'h8000_0000, 3'b101, 3'b010);
    add_entry(OP_SLT, 32'h0000_0001, 32'hffff_ffff, 3'b001, 32'h0000_0001, 3'b101, 3'b010);
    add_entry(OP_SRL, 32'hf000_0000, 32'h0000_0004, 3'b000, 32'h0f00_0000, 3'b000, 3'b010);
  endtask

  // put the next request on the port and note what it should return
  task automatic drive_next();
    ex_req_t     r;
    stim_t       s;
    logic [31:0] v;
    if (src_idx < TBL_LEN) begin
      s = stim_tbl[src_idx];
      r.op = s.op;
      r.operand_a = s.a;
      r.operand_b = s.b;
      r.waddr = REG_ADDR_W'(src_idx + 1);
      cur_exp.vote.wdata = s.wdata;
      {cur_exp.vote.err_detected, cur_exp.vote.err_corrected,
       cur_exp.vote.err_uncorrectable} = s.flags;
      cur_exp.faulty = s.faulty;
      cur_exp.lat_chk = 1'b1;
      fault_inject <= s.inj;
    end else begin
      take_bits(3, v);
      r.op = alu_op_e'(v[2:0]);
      take_bits(32, v);
      r.operand_a = v;
      take_bits(32, v);
      r.operand_b = v;
      take_bits(REG_ADDR_W, v);
      r.waddr = v[REG_ADDR_W-1:0];
      // lane 1 stays retired, lanes 0 and 2 agree
      cur_exp.vote.wdata = alu_rule(r.op, r.operand_a, r.operand_b);
      {cur_exp.vote.err_detected, cur_exp.vote.err_corrected,
       cur_exp.vote.err_uncorrectable} = 3'b000;
      cur_exp.faulty = 3'b010;
      cur_exp.lat_chk = 1'b0;
      fault_inject <= '0;
    end
    cur_exp.vote.waddr = r.waddr;
    req_valid <= (src_idx < TOTAL);
    req <= r;
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    exp_t        item;
    logic [31:0] v;
    req_valid    <= 1'b0;
    req          <= '0;
    fault_inject <= '0;
    wb_ready     <= 1'b1;
    lfsr_state = 32'h419b;
    fill_table();
    @(posedge rst_n);
    @(posedge clk);
    if (wb_valid !== 1'b0) begin
      fail_value("wb_valid_o high after reset");
    end
    check_faulty(lane_faulty, '0, "after reset");
    check_ready(req_ready, 1'b1, "after reset");
    drive_next();
    while (pops < TOTAL) begin
      @(posedge clk);
      cycle++;
      if (cycle > TIMEOUT) begin
        fail_plain($sformatf("timeout: only %0d of %0d results came back within %0d cycles",
          pops, TOTAL, TIMEOUT));
      end
      // two items in flight fill both registers, a held output then blocks the input
      check_ready(req_ready, !((exp_q.size() >= 2) && !wb_ready),
        $sformatf("cycle %0d with %0d in flight", cycle, exp_q.size()));
      // output must not move while the consumer holds it off
      if (stalled) begin
        if (wb_valid !== 1'b1) begin
          fail_value("wb_valid_o dropped while stalled");
        end
        check_vote(wb, held, "stalled output");
      end
      stalled = wb_valid && !wb_ready;
      held = wb;
      if (wb_valid && wb_ready) begin
        if (exp_q.size() == 0) begin
          fail_value("result delivered with no request pending");
        end
        item = exp_q.pop_front();
        check_vote(wb, item.vote, $sformatf("result %0d", pops));
        check_faulty(lane_faulty, item.faulty, $sformatf("result %0d", pops));
        if (item.lat_chk && (cycle != item.acc_cycle + 2)) begin
          fail_value($sformatf("result %0d arrived %0d cycles after acceptance",
            pops, cycle - item.acc_cycle));
        end
        pops++;
      end
      if (req_valid && req_ready) begin
        cur_exp.acc_cycle = cycle;
        exp_q.push_back(cur_exp);
        src_idx++;
        drive_next();
      end
      // random back-pressure once the table results are out
      if (pops >= TBL_LEN) begin
        take_bits(1, v);
        wb_ready <= v[0];
      end
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/ex_ft_pkg.sv
design/alu_lane.sv
design/alu_tmr_stage.sv
design/majority_voter.sv
design/fault_monitor.sv
design/wb_stage.sv
design/ex_stage_ft.sv
dv/clk_rst_gen.sv
dv/tb_ex_stage_ft.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the execute stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_ex_stage_ft

# a fatal check exits non-zero, keep the output for the search below
sim_out="$(./obj_dir/Vtb_ex_stage_ft 2>&1)" || true
echo "${sim_out}"

if grep -q "Test OK" <<< "${sim_out}"; then
  exit 0
else
  exit 1
fi
